/* src/mips_ex_cfg.svh */
`ifndef MIPS_EX_CFG_SVH
`define MIPS_EX_CFG_SVH

// Datapath widths
`define MIPS_XLEN       32
`define MIPS_REG_BITS   5
`define MIPS_SHAMT_BITS 5

// R-type funct codes understood by the ALU
`define MIPS_FUNCT_SLL  6'b000000
`define MIPS_FUNCT_SRL  6'b000010
`define MIPS_FUNCT_SRA  6'b000011
`define MIPS_FUNCT_SLLV 6'b000100
`define MIPS_FUNCT_SRLV 6'b000110
`define MIPS_FUNCT_SRAV 6'b000111
`define MIPS_FUNCT_JR   6'b001000
`define MIPS_FUNCT_JALR 6'b001001
`define MIPS_FUNCT_ADD  6'b100000
`define MIPS_FUNCT_ADDU 6'b100001
`define MIPS_FUNCT_SUB  6'b100010
`define MIPS_FUNCT_SUBU 6'b100011
`define MIPS_FUNCT_AND  6'b100100
`define MIPS_FUNCT_OR   6'b100101
`define MIPS_FUNCT_XOR  6'b100110
`define MIPS_FUNCT_NOR  6'b100111
`define MIPS_FUNCT_SLT  6'b101010
`define MIPS_FUNCT_SLTU 6'b101011

`endif

/* src/mips_ex_pkg.sv */
`default_nettype none

`include "mips_ex_cfg.svh"

package mips_ex_pkg;

	////////////////////////////////////////////////////////////////////////////
	// Scalar types
	////////////////////////////////////////////////////////////////////////////

	typedef logic [`MIPS_XLEN-1:0]       word_t;
	typedef logic [`MIPS_REG_BITS-1:0]   reg_idx_t;
	typedef logic [`MIPS_SHAMT_BITS-1:0] shamt_t;
	typedef logic [5:0]                  funct_t;

	// ALU operation class from the main decoder
	typedef logic [1:0] alu_op_t;
	localparam alu_op_t ALU_OP_ADD   = 2'b00;
	localparam alu_op_t ALU_OP_SUB   = 2'b01;
	localparam alu_op_t ALU_OP_FUNCT = 2'b10;

	// Control transfer resolved in EX
	typedef logic [2:0] branch_kind_t;
	localparam branch_kind_t BR_NONE = 3'd0;
	localparam branch_kind_t BR_BEQ  = 3'd1;
	localparam branch_kind_t BR_BNE  = 3'd2;
	localparam branch_kind_t BR_JR   = 3'd3;
	localparam branch_kind_t BR_JALR = 3'd4;

	////////////////////////////////////////////////////////////////////////////
	// Stage records
	////////////////////////////////////////////////////////////////////////////

	// Decoded instruction from ID
	typedef struct packed {
		word_t        pc;
		word_t        rs_val;
		word_t        rt_val;
		reg_idx_t     rs;
		reg_idx_t     rt;
		reg_idx_t     dest;
		word_t        imm;          // Already sign extended
		shamt_t       shamt;
		alu_op_t      alu_op;
		funct_t       funct;
		logic         alu_src;      // Immediate as second operand
		logic         reg_write;
		branch_kind_t branch_kind;
	} id_ex_t;

	// One bypass source from a later stage
	typedef struct packed {
		logic     reg_write;
		reg_idx_t dest;
		word_t    data;
	} fwd_t;

	// EX/MEM record
	typedef struct packed {
		word_t    alu_result;
		logic     zero;
		word_t    store_data;
		reg_idx_t dest;
		logic     reg_write;
	} ex_mem_t;

	// Fetch redirect
	typedef struct packed {
		word_t target;
	} redirect_t;

endpackage

`default_nettype wire

/* src/ex_operand_mux.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_ex_cfg.svh"

module ex_operand_mux (
	input  mips_ex_pkg::id_ex_t instr,
	input  mips_ex_pkg::fwd_t   mem_fwd,
	input  mips_ex_pkg::fwd_t   wb_fwd,
	output mips_ex_pkg::word_t  op_a,
	output mips_ex_pkg::word_t  op_b,
	output mips_ex_pkg::word_t  store_data,
	output mips_ex_pkg::word_t  fwd_rs
);

	////////////////////////////////////////////////////////////////////////////
	// Bypass network
	////////////////////////////////////////////////////////////////////////////

	// MEM beats WB beats register file
	function automatic mips_ex_pkg::word_t bypass(
		input mips_ex_pkg::reg_idx_t idx,
		input mips_ex_pkg::word_t    rf_val,
		input mips_ex_pkg::fwd_t     mem,
		input mips_ex_pkg::fwd_t     wb
	);
		mips_ex_pkg::word_t val;
		val = rf_val;
		// $zero always reads the file value
		if (idx != '0)
		begin
			if (mem.reg_write && (mem.dest == idx))
				val = mem.data;
			else if (wb.reg_write && (wb.dest == idx))
				val = wb.data;
		end
		return val;
	endfunction

	assign fwd_rs     = bypass(instr.rs, instr.rs_val, mem_fwd, wb_fwd);
	assign store_data = bypass(instr.rt, instr.rt_val, mem_fwd, wb_fwd);

	////////////////////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////////////////////

	logic                  fixed_shift;
	logic                  var_shift;
	mips_ex_pkg::shamt_t   var_amt;

	// Variable shifts only look at the low bits of rs
	assign var_amt = fwd_rs[`MIPS_SHAMT_BITS-1:0];

	// Shift class from funct
	always_comb
	begin
		fixed_shift = 1'b0;
		var_shift   = 1'b0;
		if (instr.alu_op == mips_ex_pkg::ALU_OP_FUNCT)
		begin
			case (instr.funct)
				`MIPS_FUNCT_SLL, `MIPS_FUNCT_SRL, `MIPS_FUNCT_SRA:
					fixed_shift = 1'b1;
				`MIPS_FUNCT_SLLV, `MIPS_FUNCT_SRLV, `MIPS_FUNCT_SRAV:
					var_shift = 1'b1;
				default:
					fixed_shift = 1'b0;
			endcase
		end
	end

	always_comb
	begin
		if (fixed_shift || var_shift)
		begin
			// Value to shift is rt
			op_a = store_data;
			if (fixed_shift)
				op_b = {{(`MIPS_XLEN-`MIPS_SHAMT_BITS){1'b0}}, instr.shamt};
			else
				op_b = {{(`MIPS_XLEN-`MIPS_SHAMT_BITS){1'b0}}, var_amt};
		end
		else
		begin
			op_a = fwd_rs;
			op_b = instr.alu_src ? instr.imm : store_data;
		end
	end

endmodule

`default_nettype wire

/* src/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_ex_cfg.svh"

module alu (
	input  mips_ex_pkg::word_t   operand_1,
	input  mips_ex_pkg::word_t   operand_2,
	input  mips_ex_pkg::alu_op_t alu_op,
	input  mips_ex_pkg::funct_t  funct,
	output mips_ex_pkg::word_t   result,
	output logic                 zero
);

	////////////////////////////////////////////////////////////////////////////
	// Shared datapath terms
	////////////////////////////////////////////////////////////////////////////

	mips_ex_pkg::shamt_t sh;
	mips_ex_pkg::word_t  sum;
	mips_ex_pkg::word_t  diff;
	mips_ex_pkg::word_t  sra_val;
	logic                lt_signed;
	logic                lt_unsigned;

	// Only five bits of shift count
	assign sh = operand_2[`MIPS_SHAMT_BITS-1:0];

	assign sum  = operand_1 + operand_2;
	assign diff = operand_1 - operand_2;

	// Sign fill on right shift
	assign sra_val = mips_ex_pkg::word_t'($signed(operand_1) >>> sh);

	assign lt_signed   = $signed(operand_1) < $signed(operand_2);
	assign lt_unsigned = operand_1 < operand_2;

	////////////////////////////////////////////////////////////////////////////
	// Operation decode
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		case (alu_op)
			mips_ex_pkg::ALU_OP_ADD:
				result = sum;
			mips_ex_pkg::ALU_OP_SUB:
				result = diff;
			mips_ex_pkg::ALU_OP_FUNCT:
			begin
				case (funct)
					// Shifts
					`MIPS_FUNCT_SLL, `MIPS_FUNCT_SLLV:
						result = operand_1 << sh;
					`MIPS_FUNCT_SRL, `MIPS_FUNCT_SRLV:
						result = operand_1 >> sh;
					`MIPS_FUNCT_SRA, `MIPS_FUNCT_SRAV:
						result = sra_val;

					// Arithmetic, no overflow trap
					`MIPS_FUNCT_ADD, `MIPS_FUNCT_ADDU:
						result = sum;
					`MIPS_FUNCT_SUB, `MIPS_FUNCT_SUBU:
						result = diff;

					// Jumps run a subtract, result replaced later for JALR
					`MIPS_FUNCT_JR, `MIPS_FUNCT_JALR:
						result = diff;

					// Logic
					`MIPS_FUNCT_AND:
						result = operand_1 & operand_2;
					`MIPS_FUNCT_OR:
						result = operand_1 | operand_2;
					`MIPS_FUNCT_XOR:
						result = operand_1 ^ operand_2;
					`MIPS_FUNCT_NOR:
						result = ~(operand_1 | operand_2);

					// Set on less than
					`MIPS_FUNCT_SLT:
						result = {{(`MIPS_XLEN-1){1'b0}}, lt_signed};
					`MIPS_FUNCT_SLTU:
						result = {{(`MIPS_XLEN-1){1'b0}}, lt_unsigned};

					// Unknown funct
					default:
						result = '1;
				endcase
			end
			// Unused op class
			default:
				result = '1;
		endcase
	end

	// Equality flag for BEQ/BNE
	assign zero = (result == '0);

endmodule

`default_nettype wire

/* src/branch_resolve.sv */
`timescale 1ns/1ns
`default_nettype none

module branch_resolve (
	input  logic                      clk,
	input  logic                      rst_n,
	input  logic                      valid,
	input  mips_ex_pkg::branch_kind_t branch_kind,
	input  mips_ex_pkg::word_t        pc,
	input  mips_ex_pkg::word_t        imm,
	input  mips_ex_pkg::word_t        fwd_rs,
	input  logic                      zero,
	output logic                      redirect_valid,
	output mips_ex_pkg::redirect_t    redirect
);

	logic               taken;
	mips_ex_pkg::word_t target;
	mips_ex_pkg::word_t branch_target;

	// PC relative to the delay slot
	assign branch_target = pc + mips_ex_pkg::word_t'(4) + (imm << 2);

	////////////////////////////////////////////////////////////////////////////
	// Decision
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		taken  = 1'b0;
		target = branch_target;
		case (branch_kind)
			mips_ex_pkg::BR_NONE:
				taken = 1'b0;
			mips_ex_pkg::BR_BEQ:
				taken = zero;
			mips_ex_pkg::BR_BNE:
				taken = ~zero;
			// Register jumps always leave
			mips_ex_pkg::BR_JR, mips_ex_pkg::BR_JALR:
			begin
				taken  = 1'b1;
				target = fwd_rs;
			end
			default:
				taken = 1'b0;
		endcase
	end

	// One cycle to fetch
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			redirect_valid <= 1'b0;
			redirect       <= '0;
		end
		else
		begin
			redirect_valid <= valid & taken;
			if (valid && taken)
				redirect.target <= target;
		end
	end

endmodule

`default_nettype wire

/* src/ex_result_reg.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_result_reg (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 valid,
	input  mips_ex_pkg::id_ex_t  instr,
	input  mips_ex_pkg::word_t   alu_result,
	input  logic                 zero,
	input  mips_ex_pkg::word_t   store_data,
	output logic                 out_valid,
	output mips_ex_pkg::ex_mem_t result
);

	logic               is_jalr;
	mips_ex_pkg::word_t link_addr;
	mips_ex_pkg::word_t final_result;

	// Return address skips the delay slot
	assign link_addr = instr.pc + mips_ex_pkg::word_t'(8);
	assign is_jalr   = (instr.branch_kind == mips_ex_pkg::BR_JALR);

	// Link value goes to the destination register
	assign final_result = is_jalr ? link_addr : alu_result;

	////////////////////////////////////////////////////////////////////////////
	// EX/MEM register
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			out_valid <= 1'b0;
			result    <= '0;
		end
		else
		begin
			// Strobe lasts one cycle
			out_valid <= valid;
			if (valid)
			begin
				result.alu_result <= final_result;
				// Flag stays the raw ALU compare
				result.zero       <= zero;
				result.store_data <= store_data;
				result.dest       <= instr.dest;
				result.reg_write  <= instr.reg_write;
			end
		end
	end

endmodule

`default_nettype wire

/* src/ex_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   in_valid,
	input  mips_ex_pkg::id_ex_t    in_instr,
	input  mips_ex_pkg::fwd_t      mem_fwd,
	input  mips_ex_pkg::fwd_t      wb_fwd,
	output logic                   out_valid,
	output mips_ex_pkg::ex_mem_t   out_result,
	output logic                   redirect_valid,
	output mips_ex_pkg::redirect_t out_redirect
);

	// Operands after bypass
	mips_ex_pkg::word_t op_a;
	mips_ex_pkg::word_t op_b;
	mips_ex_pkg::word_t store_data;
	mips_ex_pkg::word_t fwd_rs;

	// ALU outputs
	mips_ex_pkg::word_t alu_result;
	logic               alu_zero;

	////////////////////////////////////////////////////////////////////////////
	// Combinational front
	////////////////////////////////////////////////////////////////////////////

	ex_operand_mux u_operand_mux (
		.instr      (in_instr),
		.mem_fwd    (mem_fwd),
		.wb_fwd     (wb_fwd),
		.op_a       (op_a),
		.op_b       (op_b),
		.store_data (store_data),
		.fwd_rs     (fwd_rs)
	);

	alu u_alu (
		.operand_1 (op_a),
		.operand_2 (op_b),
		.alu_op    (in_instr.alu_op),
		.funct     (in_instr.funct),
		.result    (alu_result),
		.zero      (alu_zero)
	);

	////////////////////////////////////////////////////////////////////////////
	// Registered outputs
	////////////////////////////////////////////////////////////////////////////

	branch_resolve u_branch_resolve (
		.clk            (clk),
		.rst_n          (rst_n),
		.valid          (in_valid),
		.branch_kind    (in_instr.branch_kind),
		.pc             (in_instr.pc),
		.imm            (in_instr.imm),
		.fwd_rs         (fwd_rs),
		.zero           (alu_zero),
		.redirect_valid (redirect_valid),
		.redirect       (out_redirect)
	);

	ex_result_reg u_result_reg (
		.clk        (clk),
		.rst_n      (rst_n),
		.valid      (in_valid),
		.instr      (in_instr),
		.alu_result (alu_result),
		.zero       (alu_zero),
		.store_data (store_data),
		.out_valid  (out_valid),
		.result     (out_result)
	);

endmodule

`default_nettype wire

/* bench/ex_stage_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module ex_stage_properties (
	input logic clk,
	input logic rst_n,
	input logic in_valid,
	input logic out_valid,
	input logic redirect_valid
);

	// High once the first reset edge has been seen
	logic reset_seen = 1'b0;

	always @(posedge clk)
	begin
		if (!rst_n)
			reset_seen <= 1'b1;
	end

	// EX/MEM strobe is the input strobe delayed by one cycle
	a_out_valid_latency: assert property (@(posedge clk) disable iff (!rst_n)
		$past(rst_n) |-> (out_valid == $past(in_valid)))
		else $error("out_valid is not in_valid delayed by one cycle");

	// Redirect only for an instruction captured on the last edge
	a_redirect_has_strobe: assert property (@(posedge clk) disable iff (!rst_n)
		redirect_valid |-> $past(in_valid))
		else $error("redirect_valid without in_valid one cycle earlier");

	// Quiet outputs while reset is held
	a_quiet_in_reset: assert property (@(posedge clk)
		(reset_seen && !rst_n) |-> (!out_valid && !redirect_valid))
		else $error("valid output high during reset");

endmodule

bind ex_stage ex_stage_properties u_properties (
	.clk            (clk),
	.rst_n          (rst_n),
	.in_valid       (in_valid),
	.out_valid      (out_valid),
	.redirect_valid (redirect_valid)
);

`default_nettype wire

/* bench/ex_stage_tb.sv */
`timescale 1ns/1ns
`default_nettype none

`include "mips_ex_cfg.svh"

module ex_stage_tb;

	localparam int ROUNDS       = 4;
	localparam int RESET_CYCLES = 4;
	// One cycle per strobe or idle step over all tests
	localparam int TEST_STEPS   = 20 * ROUNDS + 31;
	localparam int CYCLE_LIMIT  = RESET_CYCLES + 2 * TEST_STEPS;

	logic                   clk;
	logic                   rst_n;
	logic                   in_valid;
	mips_ex_pkg::id_ex_t    in_instr;
	mips_ex_pkg::fwd_t      mem_fwd;
	mips_ex_pkg::fwd_t      wb_fwd;
	logic                   out_valid;
	mips_ex_pkg::ex_mem_t   out_result;
	logic                   redirect_valid;
	mips_ex_pkg::redirect_t out_redirect;

	int          errors;
	int          cycles;
	logic [15:0] lfsr;

	// Expected response to the strobe of the previous cycle
	logic                   exp_valid;
	logic                   exp_taken;
	mips_ex_pkg::ex_mem_t   exp_result;
	mips_ex_pkg::redirect_t exp_redirect;

	ex_stage u_dut (
		.clk            (clk),
		.rst_n          (rst_n),
		.in_valid       (in_valid),
		.in_instr       (in_instr),
		.mem_fwd        (mem_fwd),
		.wb_fwd         (wb_fwd),
		.out_valid      (out_valid),
		.out_result     (out_result),
		.redirect_valid (redirect_valid),
		.out_redirect   (out_redirect)
	);

	always #5 clk = ~clk;

	// Watchdog
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles > CYCLE_LIMIT)
		begin
			$display("Timeout: tests still running after %0d cycles", cycles);
			$display("Errors found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus source
	////////////////////////////////////////////////////////////////////////////

	// Galois LFSR with taps x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	// One step per bit taken
	task automatic draw_bits(input int nbits, output mips_ex_pkg::word_t val);
		int k;
		val = '0;
		for (k = 0; k < nbits; k++)
		begin
			lfsr = lfsr_next(lfsr);
			val  = {val[30:0], lfsr[0]};
		end
	endtask

	// Plain ADD with random fields and no control transfer
	task automatic random_instr(output mips_ex_pkg::id_ex_t i);
		mips_ex_pkg::word_t r;
		draw_bits(32, r);
		i.pc = {r[31:2], 2'b00};
		draw_bits(32, r);
		i.rs_val = r;
		draw_bits(32, r);
		i.rt_val = r;
		draw_bits(15, r);
		i.rs   = r[4:0];
		i.rt   = r[9:5];
		i.dest = r[14:10];
		draw_bits(16, r);
		i.imm = {{16{r[15]}}, r[15:0]};
		draw_bits(5, r);
		i.shamt       = r[4:0];
		i.alu_op      = mips_ex_pkg::ALU_OP_FUNCT;
		i.funct       = `MIPS_FUNCT_ADD;
		i.alu_src     = 1'b0;
		i.reg_write   = 1'b1;
		i.branch_kind = mips_ex_pkg::BR_NONE;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	function automatic mips_ex_pkg::word_t model_bypass(
		input mips_ex_pkg::reg_idx_t idx,
		input mips_ex_pkg::word_t    rf,
		input mips_ex_pkg::fwd_t     m,
		input mips_ex_pkg::fwd_t     w
	);
		// $zero is never bypassed
		if (idx == 5'd0)
			return rf;
		if (m.reg_write && (m.dest == idx))
			return m.data;
		if (w.reg_write && (w.dest == idx))
			return w.data;
		return rf;
	endfunction

	function automatic mips_ex_pkg::word_t model_alu(
		input mips_ex_pkg::word_t   a,
		input mips_ex_pkg::word_t   b,
		input mips_ex_pkg::alu_op_t op,
		input mips_ex_pkg::funct_t  f
	);
		logic [4:0]         n;
		mips_ex_pkg::word_t fill;
		n = b[4:0];
		// Bit positions vacated by a right shift
		fill = ~(32'hFFFF_FFFF >> n);
		if (op == mips_ex_pkg::ALU_OP_ADD)
			return a + b;
		if (op == mips_ex_pkg::ALU_OP_SUB)
			return a - b;
		if (op != mips_ex_pkg::ALU_OP_FUNCT)
			return '1;
		case (f)
			`MIPS_FUNCT_SLL, `MIPS_FUNCT_SLLV: return a << n;
			`MIPS_FUNCT_SRL, `MIPS_FUNCT_SRLV: return a >> n;
			`MIPS_FUNCT_SRA, `MIPS_FUNCT_SRAV: return (a >> n) | (a[31] ? fill : 32'h0);
			`MIPS_FUNCT_ADD, `MIPS_FUNCT_ADDU: return a + b;
			`MIPS_FUNCT_SUB, `MIPS_FUNCT_SUBU: return a - b;
			`MIPS_FUNCT_JR, `MIPS_FUNCT_JALR: return a - b;
			`MIPS_FUNCT_AND: return a & b;
			`MIPS_FUNCT_OR: return a | b;
			`MIPS_FUNCT_XOR: return a ^ b;
			`MIPS_FUNCT_NOR: return ~(a | b);
			`MIPS_FUNCT_SLT: return {31'd0, ($signed(a) < $signed(b))};
			`MIPS_FUNCT_SLTU: return {31'd0, (a < b)};
			default: return '1;
		endcase
	endfunction

	// Expected EX/MEM record and redirect for one instruction
	task automatic model_ex(
		input mips_ex_pkg::id_ex_t i,
		input mips_ex_pkg::fwd_t   m,
		input mips_ex_pkg::fwd_t   w
	);
		mips_ex_pkg::word_t rs_f;
		mips_ex_pkg::word_t rt_f;
		mips_ex_pkg::word_t a;
		mips_ex_pkg::word_t b;
		mips_ex_pkg::word_t res;
		logic               fixed_sh;
		logic               var_sh;
		logic               reg_jump;
		rs_f     = model_bypass(i.rs, i.rs_val, m, w);
		rt_f     = model_bypass(i.rt, i.rt_val, m, w);
		fixed_sh = (i.alu_op == mips_ex_pkg::ALU_OP_FUNCT) &&
			(i.funct inside {`MIPS_FUNCT_SLL, `MIPS_FUNCT_SRL, `MIPS_FUNCT_SRA});
		var_sh   = (i.alu_op == mips_ex_pkg::ALU_OP_FUNCT) &&
			(i.funct inside {`MIPS_FUNCT_SLLV, `MIPS_FUNCT_SRLV, `MIPS_FUNCT_SRAV});
		reg_jump = (i.branch_kind == mips_ex_pkg::BR_JR) ||
			(i.branch_kind == mips_ex_pkg::BR_JALR);
		// Shifts move rt into the first operand
		a = (fixed_sh || var_sh) ? rt_f : rs_f;
		if (fixed_sh)
			b = {27'd0, i.shamt};
		else if (var_sh)
			b = {27'd0, rs_f[4:0]};
		else if (i.alu_src)
			b = i.imm;
		else
			b = rt_f;
		res = model_alu(a, b, i.alu_op, i.funct);
		exp_result.zero       = (res == '0);
		exp_result.alu_result = (i.branch_kind == mips_ex_pkg::BR_JALR) ? i.pc + 32'd8 : res;
		exp_result.store_data = rt_f;
		exp_result.dest       = i.dest;
		exp_result.reg_write  = i.reg_write;
		case (i.branch_kind)
			mips_ex_pkg::BR_BEQ: exp_taken = (res == '0);
			mips_ex_pkg::BR_BNE: exp_taken = (res != '0);
			default: exp_taken = reg_jump;
		endcase
		exp_redirect.target = reg_jump ? rs_f : i.pc + 32'd4 + {i.imm[29:0], 2'b00};
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks
	////////////////////////////////////////////////////////////////////////////

	task automatic check_word(input string name, input mips_ex_pkg::word_t act,
		input mips_ex_pkg::word_t exp);
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic check_bit(input string name, input logic act, input logic exp);
		if (act !== exp)
		begin
			errors++;
			$display("[ERROR] %s: got %h, expected %h", name, act, exp);
		end
	endtask

	task automatic check_redirect(input string name, input mips_ex_pkg::redirect_t act,
		input mips_ex_pkg::redirect_t exp);
		if (act.target !== exp.target)
		begin
			errors++;
			$display("[ERROR] %s.target: got %h, expected %h", name, act.target, exp.target);
		end
	endtask

	task automatic check_outputs();
		check_bit("out_valid", out_valid, exp_valid);
		check_bit("redirect_valid", redirect_valid, exp_valid && exp_taken);
		if (exp_valid && out_valid)
		begin
			check_word("alu_result", out_result.alu_result, exp_result.alu_result);
			check_bit("zero", out_result.zero, exp_result.zero);
			check_word("store_data", out_result.store_data, exp_result.store_data);
			check_word("dest", mips_ex_pkg::word_t'(out_result.dest),
				mips_ex_pkg::word_t'(exp_result.dest));
			check_bit("reg_write", out_result.reg_write, exp_result.reg_write);
			if (exp_taken && redirect_valid)
				check_redirect("out_redirect", out_redirect, exp_redirect);
		end
	endtask

	// Data fields hold their reset value until the first strobe
	task automatic check_reset_values();
		check_word("alu_result", out_result.alu_result, '0);
		check_bit("zero", out_result.zero, 1'b0);
		check_word("store_data", out_result.store_data, '0);
		check_word("dest", mips_ex_pkg::word_t'(out_result.dest), '0);
		check_bit("reg_write", out_result.reg_write, 1'b0);
		check_redirect("out_redirect", out_redirect, '0);
	endtask

	// Drive one cycle and check the response to the previous one
	task automatic step(input logic v, input mips_ex_pkg::id_ex_t i,
		input mips_ex_pkg::fwd_t m, input mips_ex_pkg::fwd_t w);
		@(posedge clk);
		in_valid <= v;
		in_instr <= i;
		mem_fwd  <= m;
		wb_fwd   <= w;
		@(negedge clk);
		check_outputs();
		exp_valid = v;
		model_ex(i, m, w);
	endtask

	task automatic idle();
		step(1'b0, '0, '0, '0);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic test_alu_ops();
		mips_ex_pkg::funct_t ops [10];
		mips_ex_pkg::id_ex_t i;
		mips_ex_pkg::word_t  r;
		int                  n;
		int                  k;
		ops = '{`MIPS_FUNCT_ADD, `MIPS_FUNCT_ADDU, `MIPS_FUNCT_SUB, `MIPS_FUNCT_SUBU,
			`MIPS_FUNCT_AND, `MIPS_FUNCT_OR, `MIPS_FUNCT_XOR, `MIPS_FUNCT_NOR,
			`MIPS_FUNCT_SLT, `MIPS_FUNCT_SLTU};
		for (n = 0; n < ROUNDS; n++)
		begin
			for (k = 0; k < 10; k++)
			begin
				random_instr(i);
				i.funct = ops[k];
				step(1'b1, i, '0, '0);
			end
			// Add and subtract classes on register or immediate
			random_instr(i);
			draw_bits(1, r);
			i.alu_src = r[0];
			i.alu_op  = mips_ex_pkg::ALU_OP_ADD;
			step(1'b1, i, '0, '0);
			random_instr(i);
			draw_bits(1, r);
			i.alu_src = r[0];
			i.alu_op  = mips_ex_pkg::ALU_OP_SUB;
			step(1'b1, i, '0, '0);
		end
		idle();
	endtask

	task automatic test_shifts();
		mips_ex_pkg::funct_t ops [6];
		mips_ex_pkg::id_ex_t i;
		int                  n;
		int                  k;
		ops = '{`MIPS_FUNCT_SLL, `MIPS_FUNCT_SRL, `MIPS_FUNCT_SRA,
			`MIPS_FUNCT_SLLV, `MIPS_FUNCT_SRLV, `MIPS_FUNCT_SRAV};
		for (n = 0; n < ROUNDS; n++)
		begin
			for (k = 0; k < 6; k++)
			begin
				random_instr(i);
				i.funct = ops[k];
				// Negative rt on odd rounds
				if (n[0])
					i.rt_val[31] = 1'b1;
				step(1'b1, i, '0, '0);
			end
		end
		// Full sign fill
		random_instr(i);
		i.funct  = `MIPS_FUNCT_SRA;
		i.rt_val = 32'h8000_0000;
		i.shamt  = 5'd31;
		step(1'b1, i, '0, '0);
		// Upper rs bits ignored so the shift is 4
		random_instr(i);
		i.funct  = `MIPS_FUNCT_SRAV;
		i.rt_val = 32'h8765_4321;
		i.rs_val = 32'hFFFF_FFE4;
		step(1'b1, i, '0, '0);
		idle();
	endtask

	task automatic test_compare();
		mips_ex_pkg::id_ex_t i;
		random_instr(i);
		// -1 below 1 signed only
		i.funct  = `MIPS_FUNCT_SLT;
		i.rs_val = 32'hFFFF_FFFF;
		i.rt_val = 32'h0000_0001;
		step(1'b1, i, '0, '0);
		i.funct = `MIPS_FUNCT_SLTU;
		step(1'b1, i, '0, '0);
		i.funct  = `MIPS_FUNCT_SLT;
		i.rs_val = 32'h0000_0001;
		i.rt_val = 32'hFFFF_FFFF;
		step(1'b1, i, '0, '0);
		// Unknown funct and unknown op class
		i.funct = 6'b111111;
		step(1'b1, i, '0, '0);
		i.alu_op = 2'b11;
		step(1'b1, i, '0, '0);
		// Equal operands raise zero
		random_instr(i);
		i.funct  = `MIPS_FUNCT_SUB;
		i.rt_val = i.rs_val;
		step(1'b1, i, '0, '0);
		i.alu_op = mips_ex_pkg::ALU_OP_SUB;
		step(1'b1, i, '0, '0);
		idle();
	endtask

	task automatic test_forwarding();
		mips_ex_pkg::id_ex_t i;
		mips_ex_pkg::fwd_t   m;
		mips_ex_pkg::fwd_t   w;
		m = '0;
		w = '0;
		random_instr(i);
		i.rs        = 5'd5;
		i.rt        = 5'd6;
		m.reg_write = 1'b1;
		m.dest      = 5'd5;
		draw_bits(32, m.data);
		w.reg_write = 1'b1;
		w.dest      = 5'd5;
		draw_bits(32, w.data);
		// MEM over WB
		step(1'b1, i, m, w);
		m.reg_write = 1'b0;
		step(1'b1, i, m, w);
		// rt from WB seen on store_data
		w.dest = 5'd6;
		step(1'b1, i, m, w);
		m.reg_write = 1'b1;
		m.dest      = 5'd6;
		step(1'b1, i, m, w);
		// No match uses the file value
		m.dest = 5'd9;
		w.dest = 5'd9;
		step(1'b1, i, m, w);
		// $zero ignores both sources
		i.rs   = 5'd0;
		i.rt   = 5'd0;
		m.dest = 5'd0;
		w.dest = 5'd0;
		step(1'b1, i, m, w);
		idle();
	endtask

	task automatic test_branches();
		mips_ex_pkg::id_ex_t i;
		mips_ex_pkg::fwd_t   m;
		m = '0;
		random_instr(i);
		i.branch_kind = mips_ex_pkg::BR_BEQ;
		i.alu_op      = mips_ex_pkg::ALU_OP_SUB;
		i.reg_write   = 1'b0;
		i.rt_val      = i.rs_val;
		step(1'b1, i, '0, '0);
		i.rt_val = i.rs_val + 32'd1;
		step(1'b1, i, '0, '0);
		i.branch_kind = mips_ex_pkg::BR_BNE;
		step(1'b1, i, '0, '0);
		i.rt_val = i.rs_val;
		step(1'b1, i, '0, '0);
		// Backward branch
		i.imm    = 32'hFFFF_FFF0;
		i.rt_val = ~i.rs_val;
		step(1'b1, i, '0, '0);
		random_instr(i);
		i.branch_kind = mips_ex_pkg::BR_JR;
		i.funct       = `MIPS_FUNCT_JR;
		i.reg_write   = 1'b0;
		step(1'b1, i, '0, '0);
		// JALR target through the MEM bypass
		random_instr(i);
		i.branch_kind = mips_ex_pkg::BR_JALR;
		i.funct       = `MIPS_FUNCT_JALR;
		i.rs          = 5'd7;
		m.reg_write   = 1'b1;
		m.dest        = 5'd7;
		draw_bits(32, m.data);
		step(1'b1, i, m, '0);
		idle();
	endtask

	// Mixed stream with no gaps
	task automatic test_back_to_back();
		mips_ex_pkg::id_ex_t i;
		mips_ex_pkg::word_t  r;
		int                  n;
		for (n = 0; n < 2 * ROUNDS; n++)
		begin
			random_instr(i);
			draw_bits(4, r);
			i.alu_src     = r[3];
			i.branch_kind = (r[2:0] > 3'd4) ? mips_ex_pkg::BR_NONE : r[2:0];
			if (i.branch_kind == mips_ex_pkg::BR_JR)
				i.funct = `MIPS_FUNCT_JR;
			else if (i.branch_kind == mips_ex_pkg::BR_JALR)
				i.funct = `MIPS_FUNCT_JALR;
			else if (i.branch_kind != mips_ex_pkg::BR_NONE)
				i.alu_op = mips_ex_pkg::ALU_OP_SUB;
			step(1'b1, i, '0, '0);
		end
		idle();
	endtask

	initial
	begin
		clk          = 1'b0;
		rst_n        = 1'b0;
		in_valid     = 1'b0;
		in_instr     = '0;
		mem_fwd      = '0;
		wb_fwd       = '0;
		errors       = 0;
		cycles       = 0;
		lfsr         = 16'd42828;
		exp_valid    = 1'b0;
		exp_taken    = 1'b0;
		exp_result   = '0;
		exp_redirect = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		rst_n <= 1'b1;
		// Quiet outputs after reset
		idle();
		idle();
		idle();
		check_reset_values();
		test_alu_ops();
		test_shifts();
		test_compare();
		test_forwarding();
		test_branches();
		test_back_to_back();
		$display("Summary: %0d errors in %0d cycles", errors, cycles);
		if (errors == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

/* tb.f */
+incdir+src
src/mips_ex_pkg.sv
src/ex_operand_mux.sv
src/alu.sv
src/branch_resolve.sv
src/ex_result_reg.sv
src/ex_stage.sv
bench/ex_stage_properties.sv
bench/ex_stage_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the EX stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module ex_stage_tb \
	-o ex_stage_sim > build.log 2>&1 \
	|| { cat build.log; echo "FAIL: build"; exit 1; }

./obj_dir/ex_stage_sim > sim.log 2>&1 \
	|| { cat sim.log; echo "FAIL: simulator exit status"; exit 1; }

cat sim.log
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }
